// File: src/pdp8_panel_pkg.sv
// shared types and sizes for the console path, imported by every panel module.

package pdp8_panel_pkg;

    // machine word and core size.
    localparam int word_bits = 12;
    localparam int mem_words = 4096;

    // data word, used for switches, mb, memory data and the display.
    typedef logic [word_bits-1:0] pdp8_word_t;

    // core address, 4k words.
    typedef logic [$clog2(mem_words)-1:0] pdp8_addr_t;

    // console commands, one per key.
    typedef enum logic [2:0]
    {
        op_none,
        op_load_addr,
        op_deposit,
        op_examine,
        op_clear
    } panel_op_e;

    // data display source.
    typedef enum logic [1:0]
    {
        sel_ma,
        sel_mb,
        sel_md,   // word at current ma.
        sel_lamp  // all lamps on.
    } disp_sel_e;

    // one-cycle command with the switch value taken at the key press.
    typedef struct packed
    {
        panel_op_e  op;
        pdp8_word_t sr;
    } panel_cmd_t;

    // register view for the display.
    typedef struct packed
    {
        pdp8_addr_t ma;
        pdp8_word_t mb;
        pdp8_word_t md;
    } panel_regs_t;

endpackage

// File: src/front_panel.sv
// console key front end, turns key presses into single command pulses for the memory.
`timescale 1ns/100ps

module front_panel
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  pdp8_panel_pkg::pdp8_word_t sr,
    input  logic                      load_addr,
    input  logic                      dep,
    input  logic                      exam,
    input  logic                      clear,
    output pdp8_panel_pkg::panel_cmd_t cmd
);

    import pdp8_panel_pkg::*;

    // one bit per console key, highest priority first.
    typedef struct packed
    {
        logic clear;
        logic load_addr;
        logic dep;
        logic exam;
    } panel_keys_t;

    panel_keys_t keys_in;
    panel_keys_t sync_1;
    panel_keys_t sync_2;
    panel_keys_t prev;
    panel_keys_t press;

    panel_op_e   op_next;
    panel_op_e   op_q;
    pdp8_word_t  sr_q;

    assign keys_in = '{clear: clear, load_addr: load_addr, dep: dep, exam: exam};

    // two-flop synchronizer plus last value for edge detection.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
            prev   <= '0;
        end
        else
        begin
            sync_1 <= keys_in;
            sync_2 <= sync_1;
            prev   <= sync_2;
        end
    end

    assign press = sync_2 & ~prev; // rising edge only.

    // clear beats load address beats deposit beats examine.
    always_comb
    begin
        op_next = op_none;
        if (press.clear)
            op_next = op_clear;
        else if (press.load_addr)
            op_next = op_load_addr;
        else if (press.dep)
            op_next = op_deposit;
        else if (press.exam)
            op_next = op_examine;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            op_q <= op_none;
        else
            op_q <= op_next;
    end

    // switches captured with the command.
    always_ff @(posedge clk)
    begin
        sr_q <= sr;
    end

    assign cmd = '{op: op_q, sr: sr_q};

    // a press yields one pulse, never two in a row.
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (op_q != op_none) |=> (op_q == op_none));

endmodule

// File: src/panel_memory.sv
// 4k x 12 core with ma and mb that executes the console commands from the front panel.
`timescale 1ns/100ps

module panel_memory
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  pdp8_panel_pkg::panel_cmd_t  cmd,
    output pdp8_panel_pkg::panel_regs_t regs
);

    import pdp8_panel_pkg::*;

    pdp8_word_t core [mem_words];

    pdp8_addr_t ma;
    pdp8_addr_t ma_next;
    pdp8_word_t mb;
    pdp8_word_t mb_next;
    pdp8_word_t md;
    logic       write_en;

    // next register values for the current command.
    always_comb
    begin
        ma_next  = ma;
        mb_next  = mb;
        write_en = 1'b0;
        case (cmd.op)
            op_load_addr:
            begin
                ma_next = cmd.sr;
            end
            op_deposit:
            begin
                write_en = 1'b1;
                mb_next  = cmd.sr;
                ma_next  = ma + pdp8_addr_t'(1); // wraps past 7777.
            end
            op_examine:
            begin
                mb_next = core[ma];
                ma_next = ma + pdp8_addr_t'(1);
            end
            op_clear:
            begin
                ma_next = '0;
                mb_next = '0;
            end
            default:
            begin
                ma_next = ma;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ma <= '0;
            mb <= '0;
        end
        else
        begin
            ma <= ma_next;
            mb <= mb_next;
        end
    end

    // deposit writes the old ma; md reads the new one.
    always_ff @(posedge clk)
    begin
        if (write_en)
            core[ma] <= cmd.sr;
        md <= core[ma_next];
    end

    assign regs = '{ma: ma, mb: mb, md: md};

    // ma only moves on a command.
    a_ma_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.op == op_none) |=> (ma == $past(ma)));

    // deposit and examine step ma by one modulo 4096.
    a_ma_step: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.op == op_deposit || cmd.op == op_examine)
        |=> (ma == pdp8_addr_t'($past(ma) + pdp8_addr_t'(1))));

endmodule

// File: src/display_mux.sv
// console data display, registers ma, mb, the word at ma or the lamp test onto the lamps.
`timescale 1ns/100ps

module display_mux
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  pdp8_panel_pkg::disp_sel_e   dsel,
    input  pdp8_panel_pkg::panel_regs_t regs,
    output pdp8_panel_pkg::pdp8_word_t  ds
);

    import pdp8_panel_pkg::*;

    pdp8_word_t ds_next;

    // source select.
    always_comb
    begin
        case (dsel)
            sel_ma:
            begin
                ds_next = regs.ma;
            end
            sel_mb:
            begin
                ds_next = regs.mb;
            end
            sel_md:
            begin
                ds_next = regs.md; // follows ma.
            end
            sel_lamp:
            begin
                ds_next = '1;
            end
            default:
            begin
                ds_next = '0;
            end
        endcase
    end

    // lamps dark in reset.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ds <= '0;
        else
            ds <= ds_next;
    end

    // the select switch must be a real level once running.
    a_dsel_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(dsel));

endmodule

// File: src/pdp8_panel.sv
// console path top, front panel keys to core memory to the data display lamps.
`timescale 1ns/100ps

module pdp8_panel
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  pdp8_panel_pkg::pdp8_word_t sr,
    input  pdp8_panel_pkg::disp_sel_e  dsel,
    input  logic                      load_addr,
    input  logic                      dep,
    input  logic                      exam,
    input  logic                      clear,
    output pdp8_panel_pkg::pdp8_word_t ds
);

    import pdp8_panel_pkg::*;

    panel_cmd_t  cmd;  // one-cycle command pulse.
    panel_regs_t regs;

    front_panel fp
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .sr        (sr),
        .load_addr (load_addr),
        .dep       (dep),
        .exam      (exam),
        .clear     (clear),
        .cmd       (cmd)
    );

    panel_memory mem
    (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .regs  (regs)
    );

    display_mux dm
    (
        .clk   (clk),
        .rst_n (rst_n),
        .dsel  (dsel),
        .regs  (regs),
        .ds    (ds)
    );

endmodule

// File: tests/panel_checks.svh
// testbench helpers for the console path, included inside the testbench module body.
`ifndef PANEL_CHECKS_SVH
`define PANEL_CHECKS_SVH

// galois lfsr, right shift, one step per bit taken.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
        next = next ^ 32'hd000_0001;
    return next;
endfunction

// what the lamps should show for a select and the model registers.
function automatic pdp8_word_t expected_display(input disp_sel_e sel, input pdp8_addr_t ma,
                                                input pdp8_word_t mb, input pdp8_word_t md);
    pdp8_word_t value;
    case (sel)
        sel_ma:
        begin
            value = ma;
        end
        sel_mb:
        begin
            value = mb;
        end
        sel_md:
        begin
            value = md;
        end
        default:
        begin
            value = {word_bits{1'b1}}; // lamp test.
        end
    endcase
    return value;
endfunction

// display word compare, stops at the first mismatch.
task automatic check_word(input string name, input pdp8_word_t actual,
                          input pdp8_word_t expected);
    if (actual !== expected)
    begin
        $display("ERR time %0t: %s = %o, expected %o", $time, name, actual, expected);
        $display("Test failed");
        $fatal(1, "display word mismatch");
    end
endtask

`endif

// File: tests/pdp8_panel_tb.sv
// testbench for the console path, presses keys and checks the lamps against a model.
`timescale 1ns/100ps

module pdp8_panel_tb;

    import pdp8_panel_pkg::*;

    localparam int timeout_cycles = 4000; // ~150 operations at 13 cycles, plus margin.
    localparam int run_length     = 64;

    logic       clk;
    logic       rst_n;
    pdp8_word_t sr;
    disp_sel_e  dsel;
    logic       load_addr;
    logic       dep;
    logic       exam;
    logic       clear;
    pdp8_word_t ds;

    // model of core, ma and mb.
    pdp8_word_t model_core [mem_words];
    logic       model_valid [mem_words];
    pdp8_addr_t model_ma;
    pdp8_word_t model_mb;

    logic [31:0] lfsr_state;
    int          cycle_count;
    logic        check_armed;
    pdp8_word_t  check_exp;

    `include "panel_checks.svh"

    pdp8_panel UUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .sr        (sr),
        .dsel      (dsel),
        .load_addr (load_addr),
        .dep       (dep),
        .exam      (exam),
        .clear     (clear),
        .ds        (ds)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // compare process, ds is settled by the falling edge.
    always @(negedge clk)
    begin
        if (check_armed)
            check_word("ds", ds, check_exp);
    end

    task automatic take_bits(input int count, output pdp8_word_t bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits       = {bits[word_bits-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // select a source and check it one cycle later.
    task automatic check_display(input disp_sel_e sel);
        @(negedge clk);
        dsel        <= sel;
        check_exp   <= expected_display(sel, model_ma, model_mb, model_core[model_ma]);
        check_armed <= (sel != sel_md) || model_valid[model_ma]; // unwritten core is skipped.
        @(negedge clk);
        check_armed <= 1'b0;
    endtask

    task automatic press_keys(input logic k_clear, input logic k_load, input logic k_dep,
                              input logic k_exam, input pdp8_word_t value);
        @(negedge clk);
        sr        <= value;
        clear     <= k_clear;
        load_addr <= k_load;
        dep       <= k_dep;
        exam      <= k_exam;
        repeat (3) @(negedge clk);
        clear     <= 1'b0;
        load_addr <= 1'b0;
        dep       <= 1'b0;
        exam      <= 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic apply_model(input panel_op_e op, input pdp8_word_t value);
        case (op)
            op_load_addr:
            begin
                model_ma = value;
            end
            op_deposit:
            begin
                model_core[model_ma]  = value;
                model_valid[model_ma] = 1'b1;
                model_mb              = value;
                model_ma              = model_ma + 12'd1;
            end
            op_examine:
            begin
                model_mb = model_core[model_ma];
                model_ma = model_ma + 12'd1;
            end
            op_clear:
            begin
                model_ma = '0;
                model_mb = '0;
            end
            default:
            begin
                model_mb = model_mb;
            end
        endcase
    endtask

    task automatic load_address(input pdp8_word_t value);
        press_keys(1'b0, 1'b1, 1'b0, 1'b0, value);
        apply_model(op_load_addr, value);
    endtask

    initial
    begin
        pdp8_addr_t start;
        pdp8_word_t value;
        disp_sel_e  sel;
        clk         = 1'b0;
        rst_n       = 1'b0;
        sr          = '0;
        dsel        = sel_ma;
        load_addr   = 1'b0;
        dep         = 1'b0;
        exam        = 1'b0;
        clear       = 1'b0;
        lfsr_state  = 32'hc9d4492e;
        cycle_count = 0;
        check_armed = 1'b0;
        check_exp   = '0;
        model_ma    = '0;
        model_mb    = '0;
        for (int i = 0; i < mem_words; i++)
        begin
            model_core[i]  = '0;
            model_valid[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        rst_n <= 1'b1;

        check_display(sel_ma);
        check_display(sel_mb);

        take_bits(word_bits, value);
        load_address(value);
        check_display(sel_ma);

        // start near the top so the run wraps through address 0.
        take_bits(6, value);
        if (value == '0)
            value = 12'd1;
        start = 12'o7700 + value;
        load_address(start);
        for (int i = 0; i < run_length; i++)
        begin
            take_bits(word_bits, value);
            press_keys(1'b0, 1'b0, 1'b1, 1'b0, value);
            apply_model(op_deposit, value);
            check_display(sel_mb);
            check_display(sel_ma);
        end

        load_address(start);
        for (int i = 0; i < run_length; i++)
        begin
            press_keys(1'b0, 1'b0, 1'b0, 1'b1, '0);
            apply_model(op_examine, '0);
            check_display(sel_mb);
            check_display(sel_md);
            check_display(sel_ma);
        end

        // clear wins over deposit.
        take_bits(word_bits, value);
        press_keys(1'b1, 1'b0, 1'b1, 1'b0, value);
        apply_model(op_clear, value);
        check_display(sel_ma);
        check_display(sel_mb);
        press_keys(1'b0, 1'b0, 1'b0, 1'b1, '0);
        apply_model(op_examine, '0);
        check_display(sel_mb);
        check_display(sel_ma);

        check_display(sel_lamp);
        take_bits(2, value);
        sel = disp_sel_e'(value[1:0]);
        if (sel == sel_lamp)
            sel = sel_ma;
        check_display(sel);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tests
src/pdp8_panel_pkg.sv
src/front_panel.sv
src/panel_memory.sv
src/display_mux.sv
src/pdp8_panel.sv
tests/pdp8_panel_tb.sv

// File: run.sh
#!/bin/sh
# builds the console path testbench with verilator, runs it, and checks sim.log.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module pdp8_panel_tb -f filelist.f \
    -o pdp8_panel_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/pdp8_panel_sim > sim.log 2>&1

grep -qx "Test completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
